// ==== hw/rvIsaPkg.sv ====
package rvIsaPkg;

  // data and instruction word
  typedef logic [31:0] wordT;

  // architectural register index
  typedef logic [4:0] regIdxT;

  typedef logic [6:0] opcodeT;
  typedef logic [2:0] funct3T;

  // major opcodes of the supported subset
  localparam opcodeT opOp    = 7'b0110011;
  localparam opcodeT opImm   = 7'b0010011;
  localparam opcodeT opLoad  = 7'b0000011;
  localparam opcodeT opStore = 7'b0100011;

  // funct3 values
  localparam funct3T f3AddSub = 3'b000;
  localparam funct3T f3Xor    = 3'b100;
  localparam funct3T f3Or     = 3'b110;
  localparam funct3T f3And    = 3'b111;
  // only word-sized loads and stores
  localparam funct3T f3Word   = 3'b010;

  // instruction bit 30, set for SUB and clear for ADD
  localparam int funct7Sub = 30;

endpackage

// ==== hw/pipePkg.sv ====
package pipePkg;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor
  } aluOpE;

  // where an execute operand comes from
  typedef enum logic [1:0] {
    fwdNone,
    fwdMem,
    fwdWb
  } fwdSelE;

  typedef struct packed {
    aluOpE aluOp;
    // immediate on the right-hand ALU input
    logic  aluSrc;
    logic  memRead;
    logic  memWrite;
    logic  memToReg;
    logic  regWrite;
  } ctrlT;

  typedef struct packed {
    logic          valid;
    rvIsaPkg::wordT pc;
    rvIsaPkg::wordT instr;
  } ifIdT;

  typedef struct packed {
    logic             valid;
    ctrlT             ctrl;
    rvIsaPkg::regIdxT rs1;
    rvIsaPkg::regIdxT rs2;
    rvIsaPkg::regIdxT rd;
    rvIsaPkg::wordT   rs1Val;
    rvIsaPkg::wordT   rs2Val;
    rvIsaPkg::wordT   imm;
  } idExT;

  typedef struct packed {
    logic             valid;
    ctrlT             ctrl;
    rvIsaPkg::regIdxT rd;
    rvIsaPkg::wordT   aluResult;
    rvIsaPkg::wordT   storeData;
  } exMemT;

  typedef struct packed {
    logic             valid;
    logic             memToReg;
    logic             regWrite;
    rvIsaPkg::regIdxT rd;
    rvIsaPkg::wordT   memData;
    rvIsaPkg::wordT   aluResult;
  } memWbT;

endpackage

// ==== hw/instructionFetch.sv ====
`timescale 1ns/100ps

module instructionFetch #(
  parameter int imemWords = 64
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         stall,
  input  logic                         progWe,
  input  logic [$clog2(imemWords)-1:0] progAddr,
  input  rvIsaPkg::wordT               progData,
  output pipePkg::ifIdT                ifId
);

  localparam int idxW = $clog2(imemWords);

  rvIsaPkg::wordT  imem [imemWords];
  rvIsaPkg::wordT  pc;
  logic [idxW-1:0] fetchIdx;

  // word addressed, upper pc bits ignored so reads wrap
  assign fetchIdx = pc[idxW+1:2];

  // program load port
  always_ff @(posedge clk) begin
    if (progWe) begin
      imem[progAddr] <= progData;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc         <= '0;
      ifId.valid <= 1'b0;
    end else if (!stall) begin
      pc         <= pc + 32'd4;
      ifId.valid <= 1'b1;
      ifId.pc    <= pc;
      ifId.instr <= imem[fetchIdx];
    end
  end

endmodule

// ==== hw/registerFile.sv ====
`timescale 1ns/100ps

module registerFile (
  input  logic             clk,
  input  rvIsaPkg::regIdxT rs1,
  input  rvIsaPkg::regIdxT rs2,
  input  rvIsaPkg::regIdxT rd,
  input  logic             we,
  input  rvIsaPkg::wordT   wd,
  output rvIsaPkg::wordT   rs1Val,
  output rvIsaPkg::wordT   rs2Val
);

  rvIsaPkg::wordT regs [32];

  // x0 reads zero and a same-cycle write is passed through
  function automatic rvIsaPkg::wordT readPort(rvIsaPkg::regIdxT idx);
    if (idx == '0) begin
      return '0;
    end else if (we && idx == rd) begin
      return wd;
    end
    return regs[idx];
  endfunction

  always_ff @(posedge clk) begin
    if (we && rd != '0) begin
      regs[rd] <= wd;
    end
  end

  always_comb begin
    rs1Val = readPort(rs1);
    rs2Val = readPort(rs2);
  end

endmodule

// ==== hw/decodeStage.sv ====
`timescale 1ns/100ps

module decodeStage (
  input  logic             clk,
  input  logic             rstN,
  input  pipePkg::ifIdT    ifId,
  input  rvIsaPkg::wordT   rs1Val,
  input  rvIsaPkg::wordT   rs2Val,
  output rvIsaPkg::regIdxT rs1,
  output rvIsaPkg::regIdxT rs2,
  output logic             stall,
  output pipePkg::idExT    idEx
);

  rvIsaPkg::wordT   instr;
  rvIsaPkg::opcodeT opcode;
  rvIsaPkg::funct3T funct3;
  rvIsaPkg::regIdxT rd;
  pipePkg::ctrlT    ctrl;
  rvIsaPkg::wordT   imm;
  logic             known;
  logic             usesRs2;

  assign instr  = ifId.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  always_comb begin
    ctrl       = '0;
    ctrl.aluOp = pipePkg::aluAdd;
    known      = 1'b1;
    usesRs2    = 1'b0;
    unique case (opcode)
      rvIsaPkg::opOp: begin
        ctrl.regWrite = 1'b1;
        usesRs2       = 1'b1;
        unique case (funct3)
          rvIsaPkg::f3AddSub: begin
            ctrl.aluOp = instr[rvIsaPkg::funct7Sub] ? pipePkg::aluSub : pipePkg::aluAdd;
          end
          rvIsaPkg::f3Xor: ctrl.aluOp = pipePkg::aluXor;
          rvIsaPkg::f3Or:  ctrl.aluOp = pipePkg::aluOr;
          rvIsaPkg::f3And: ctrl.aluOp = pipePkg::aluAnd;
          default:         known      = 1'b0;
        endcase
      end
      rvIsaPkg::opImm: begin
        // ADDI only
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
        known         = (funct3 == rvIsaPkg::f3AddSub);
      end
      rvIsaPkg::opLoad: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memRead  = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
        known         = (funct3 == rvIsaPkg::f3Word);
      end
      rvIsaPkg::opStore: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
        usesRs2       = 1'b1;
        known         = (funct3 == rvIsaPkg::f3Word);
      end
      default: known = 1'b0;
    endcase
  end

  // S-type splits the offset around rd
  assign imm = (opcode == rvIsaPkg::opStore) ?
               {{20{instr[31]}}, instr[31:25], instr[11:7]} :
               {{20{instr[31]}}, instr[31:20]};

  // load in execute feeding this instruction
  assign stall = ifId.valid && idEx.valid && idEx.ctrl.memRead && idEx.rd != '0 &&
                 (idEx.rd == rs1 || (usesRs2 && idEx.rd == rs2));

  always_ff @(posedge clk) begin
    idEx.ctrl   <= ctrl;
    idEx.rs1    <= rs1;
    idEx.rs2    <= rs2;
    idEx.rd     <= rd;
    idEx.rs1Val <= rs1Val;
    idEx.rs2Val <= rs2Val;
    idEx.imm    <= imm;
    if (!rstN) begin
      idEx.valid <= 1'b0;
    end else begin
      // bubble on stall or unknown opcode
      idEx.valid <= ifId.valid && known && !stall;
    end
  end

endmodule

// ==== hw/forwardingUnit.sv ====
`timescale 1ns/100ps

module forwardingUnit (
  input  rvIsaPkg::regIdxT readIdx,
  input  rvIsaPkg::regIdxT memRd,
  input  logic             memWrites,
  input  rvIsaPkg::regIdxT wbRd,
  input  logic             wbWrites,
  output pipePkg::fwdSelE  sel
);

  logic memHit;
  logic wbHit;

  // x0 is never forwarded
  assign memHit = memWrites && memRd == readIdx && readIdx != '0;
  assign wbHit  = wbWrites && wbRd == readIdx && readIdx != '0;

  always_comb begin
    // younger result in memory wins
    if (memHit) begin
      sel = pipePkg::fwdMem;
    end else if (wbHit) begin
      sel = pipePkg::fwdWb;
    end else begin
      sel = pipePkg::fwdNone;
    end
  end

endmodule

// ==== hw/executeStage.sv ====
`timescale 1ns/100ps

module executeStage (
  input  logic            clk,
  input  logic            rstN,
  input  pipePkg::idExT   idEx,
  input  pipePkg::fwdSelE lhsSel,
  input  pipePkg::fwdSelE rhsSel,
  input  rvIsaPkg::wordT  memFwd,
  input  rvIsaPkg::wordT  wbFwd,
  output pipePkg::exMemT  exMem
);

  rvIsaPkg::wordT lhs;
  rvIsaPkg::wordT rs2Fwd;
  rvIsaPkg::wordT rhs;
  rvIsaPkg::wordT aluResult;

  function automatic rvIsaPkg::wordT pickOperand(pipePkg::fwdSelE sel, rvIsaPkg::wordT regVal);
    unique case (sel)
      pipePkg::fwdMem: return memFwd;
      pipePkg::fwdWb:  return wbFwd;
      default:         return regVal;
    endcase
  endfunction

  always_comb begin
    lhs    = pickOperand(lhsSel, idEx.rs1Val);
    rs2Fwd = pickOperand(rhsSel, idEx.rs2Val);
  end

  // immediate replaces rs2 after forwarding
  assign rhs    = idEx.ctrl.aluSrc ? idEx.imm : rs2Fwd;

  always_comb begin
    unique case (idEx.ctrl.aluOp)
      pipePkg::aluSub: aluResult = lhs - rhs;
      pipePkg::aluAnd: aluResult = lhs & rhs;
      pipePkg::aluOr:  aluResult = lhs | rhs;
      pipePkg::aluXor: aluResult = lhs ^ rhs;
      default:         aluResult = lhs + rhs;
    endcase
  end

  always_ff @(posedge clk) begin
    exMem.ctrl      <= idEx.ctrl;
    exMem.rd        <= idEx.rd;
    exMem.aluResult <= aluResult;
    exMem.storeData <= rs2Fwd;
    if (!rstN) begin
      exMem.valid <= 1'b0;
    end else begin
      exMem.valid <= idEx.valid;
    end
  end

endmodule

// ==== hw/memoryStage.sv ====
`timescale 1ns/100ps

module memoryStage #(
  parameter int dmemWords = 16
) (
  input  logic           clk,
  input  logic           rstN,
  input  pipePkg::exMemT exMem,
  output pipePkg::memWbT memWb
);

  localparam int idxW = $clog2(dmemWords);

  rvIsaPkg::wordT  dmem [dmemWords];
  logic [idxW-1:0] wordIdx;

  // address bits above the memory size are dropped
  assign wordIdx = exMem.aluResult[idxW+1:2];

  always_ff @(posedge clk) begin
    if (rstN && exMem.valid && exMem.ctrl.memWrite) begin
      dmem[wordIdx] <= exMem.storeData;
    end
  end

  always_ff @(posedge clk) begin
    memWb.memToReg  <= exMem.ctrl.memToReg;
    memWb.regWrite  <= exMem.ctrl.regWrite;
    memWb.rd        <= exMem.rd;
    // asynchronous read, registered here
    memWb.memData   <= dmem[wordIdx];
    memWb.aluResult <= exMem.aluResult;
    if (!rstN) begin
      memWb.valid <= 1'b0;
    end else begin
      memWb.valid <= exMem.valid;
    end
  end

endmodule

// ==== hw/cpu.sv ====
`timescale 1ns/100ps

module cpu #(
  parameter int imemWords = 64,
  parameter int dmemWords = 16
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         progWe,
  input  logic [$clog2(imemWords)-1:0] progAddr,
  input  rvIsaPkg::wordT               progData,
  output logic                         wbValid,
  output rvIsaPkg::regIdxT             wbRd,
  output rvIsaPkg::wordT               wbData
);

  pipePkg::ifIdT    ifId;
  pipePkg::idExT    idEx;
  pipePkg::exMemT   exMem;
  pipePkg::memWbT   memWb;
  logic             stall;
  rvIsaPkg::regIdxT rs1;
  rvIsaPkg::regIdxT rs2;
  rvIsaPkg::wordT   rs1Val;
  rvIsaPkg::wordT   rs2Val;
  pipePkg::fwdSelE  lhsSel;
  pipePkg::fwdSelE  rhsSel;
  logic             memWrites;
  logic             wbWrites;

  instructionFetch #(.imemWords(imemWords)) instructionFetch (
    .clk(clk),
    .rstN(rstN),
    .stall(stall),
    .progWe(progWe),
    .progAddr(progAddr),
    .progData(progData),
    .ifId(ifId)
  );

  registerFile registerFile (
    .clk(clk),
    .rs1(rs1),
    .rs2(rs2),
    .rd(wbRd),
    .we(wbValid),
    .wd(wbData),
    .rs1Val(rs1Val),
    .rs2Val(rs2Val)
  );

  decodeStage decodeStage (
    .clk(clk),
    .rstN(rstN),
    .ifId(ifId),
    .rs1Val(rs1Val),
    .rs2Val(rs2Val),
    .rs1(rs1),
    .rs2(rs2),
    .stall(stall),
    .idEx(idEx)
  );

  // hazard handling, index 0 is filtered inside the units
  assign memWrites = exMem.valid && exMem.ctrl.regWrite;
  assign wbWrites  = memWb.valid && memWb.regWrite;

  forwardingUnit lhsForwardingUnit (
    .readIdx(idEx.rs1),
    .memRd(exMem.rd),
    .memWrites(memWrites),
    .wbRd(memWb.rd),
    .wbWrites(wbWrites),
    .sel(lhsSel)
  );

  forwardingUnit rhsForwardingUnit (
    .readIdx(idEx.rs2),
    .memRd(exMem.rd),
    .memWrites(memWrites),
    .wbRd(memWb.rd),
    .wbWrites(wbWrites),
    .sel(rhsSel)
  );

  executeStage executeStage (
    .clk(clk),
    .rstN(rstN),
    .idEx(idEx),
    .lhsSel(lhsSel),
    .rhsSel(rhsSel),
    .memFwd(exMem.aluResult),
    .wbFwd(wbData),
    .exMem(exMem)
  );

  memoryStage #(.dmemWords(dmemWords)) memoryStage (
    .clk(clk),
    .rstN(rstN),
    .exMem(exMem),
    .memWb(memWb)
  );

  // write-back mux
  assign wbData  = memWb.memToReg ? memWb.memData : memWb.aluResult;
  assign wbRd    = memWb.rd;
  assign wbValid = wbWrites && memWb.rd != '0;

endmodule

// ==== tb/cpuTb.sv ====
`timescale 1ns/100ps

module cpuTb;

  localparam int imemWords  = 64;
  localparam int dmemWords  = 16;
  localparam int progLen    = 40;
  localparam int drainLimit = 400;
  localparam int idleCycles = 20;
  // ADDI x0, x0, 0
  localparam logic [31:0] nop = 32'h00000013;

  // instruction kinds of the generated program
  localparam int kAdd  = 0;
  localparam int kSub  = 1;
  localparam int kAnd  = 2;
  localparam int kOr   = 3;
  localparam int kXor  = 4;
  localparam int kAddi = 5;
  localparam int kLw   = 6;
  localparam int kSw   = 7;

  logic        clk;
  logic        rstN;
  logic        progWe;
  logic [5:0]  progAddr;
  logic [31:0] progData;
  logic        wbValid;
  logic [4:0]  wbRd;
  logic [31:0] wbData;

  integer      seed = 89;
  int          errors = 0;
  int          writesSeen = 0;
  int          expWrites = 0;
  int          kind [progLen];
  int          rdF [progLen];
  int          rs1F [progLen];
  int          rs2F [progLen];
  int          immF [progLen];
  logic [31:0] prog [progLen];
  logic [31:0] expRd [$];
  logic [31:0] expData [$];

  cpu #(.imemWords(imemWords), .dmemWords(dmemWords)) dut (
    .clk(clk),
    .rstN(rstN),
    .progWe(progWe),
    .progAddr(progAddr),
    .progData(progData),
    .wbValid(wbValid),
    .wbRd(wbRd),
    .wbData(wbData)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
    if (got !== expected) begin
      $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, expected);
      errors++;
    end
  endtask

  function automatic int randBelow(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic int srcReg();
    return 1 + randBelow(7);
  endfunction

  // x0 now and then, its result must vanish
  function automatic int dstReg();
    if (randBelow(8) == 0) begin
      return 0;
    end
    return 1 + randBelow(7);
  endfunction

  // byte offset of a data word plus a multiple of the memory size
  function automatic int wrappedOffset(int word);
    return 4 * word + 64 * (randBelow(5) - 2);
  endfunction

  function automatic logic [31:0] encode(int k, int rd, int rs1, int rs2, int imm);
    logic [4:0]  d;
    logic [4:0]  s1;
    logic [4:0]  s2;
    logic [11:0] i12;
    d   = rd[4:0];
    s1  = rs1[4:0];
    s2  = rs2[4:0];
    i12 = imm[11:0];
    case (k)
      kAdd:    return {7'h00, s2, s1, 3'b000, d, 7'h33};
      kSub:    return {7'h20, s2, s1, 3'b000, d, 7'h33};
      kAnd:    return {7'h00, s2, s1, 3'b111, d, 7'h33};
      kOr:     return {7'h00, s2, s1, 3'b110, d, 7'h33};
      kXor:    return {7'h00, s2, s1, 3'b100, d, 7'h33};
      kAddi:   return {i12, s1, 3'b000, d, 7'h13};
      kLw:     return {i12, s1, 3'b010, d, 7'h03};
      default: return {i12[11:5], s2, s1, 3'b010, i12[4:0], 7'h23};
    endcase
  endfunction

  // register setup, 16 stores over all data words, then a random body
  task automatic buildProgram();
    int prevLoadRd;
    prevLoadRd = 0;
    for (int i = 0; i < progLen; i++) begin
      rdF[i]  = 0;
      rs1F[i] = 0;
      rs2F[i] = 0;
      immF[i] = 0;
      if (i < 7) begin
        kind[i] = kAddi;
        rdF[i]  = i + 1;
        immF[i] = randBelow(4096) - 2048;
      end else if (i < 23) begin
        kind[i] = kSw;
        rs2F[i] = srcReg();
        immF[i] = wrappedOffset(i - 7);
      end else begin
        kind[i] = randBelow(8);
        rdF[i]  = dstReg();
        rs1F[i] = srcReg();
        rs2F[i] = srcReg();
        if (kind[i] == kAddi) begin
          immF[i] = randBelow(4096) - 2048;
        end else if (kind[i] == kLw || kind[i] == kSw) begin
          rs1F[i] = 0;
          immF[i] = wrappedOffset(randBelow(16));
        end
        // push more loads straight into a consumer
        if (prevLoadRd != 0 && randBelow(2) == 0) begin
          if (kind[i] == kSw) begin
            rs2F[i] = prevLoadRd;
          end else if (kind[i] != kLw) begin
            rs1F[i] = prevLoadRd;
          end
        end
      end
      prevLoadRd = (kind[i] == kLw) ? rdF[i] : 0;
      prog[i] = encode(kind[i], rdF[i], rs1F[i], rs2F[i], immF[i]);
    end
  endtask

  // in-order ISA model, fills the expected write-back queues
  task automatic runModel();
    logic [31:0] regs [8];
    logic [31:0] dmem [dmemWords];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] result;
    int          widx;
    bit          writes;
    for (int r = 0; r < 8; r++) begin
      regs[r] = '0;
    end
    for (int i = 0; i < progLen; i++) begin
      a      = regs[rs1F[i]];
      b      = regs[rs2F[i]];
      addr   = a + immF[i];
      widx   = int'((addr >> 2) % dmemWords);
      writes = 1'b1;
      result = '0;
      case (kind[i])
        kAdd:  result = a + b;
        kSub:  result = a - b;
        kAnd:  result = a & b;
        kOr:   result = a | b;
        kXor:  result = a ^ b;
        kAddi: result = a + immF[i];
        kLw:   result = dmem[widx];
        default: begin
          dmem[widx] = b;
          writes     = 1'b0;
        end
      endcase
      if (writes && rdF[i] != 0) begin
        regs[rdF[i]] = result;
        expRd.push_back(rdF[i]);
        expData.push_back(result);
      end
    end
  endtask

  always @(posedge clk) begin
    if (wbValid) begin
      writesSeen++;
      if (expRd.size() == 0) begin
        $display("write-back to x%0d arrived with no write left in the model", wbRd);
        errors++;
      end else begin
        check("wbRd", {27'b0, wbRd}, expRd.pop_front());
        check("wbData", wbData, expData.pop_front());
      end
    end
  end

  initial begin
    int waited;
    rstN     = 1'b0;
    progWe   = 1'b0;
    progAddr = '0;
    progData = '0;
    buildProgram();
    runModel();
    expWrites = expRd.size();
    for (int a = 0; a < imemWords; a++) begin
      @(negedge clk);
      progWe   = 1'b1;
      progAddr = a[5:0];
      if (a < progLen) begin
        progData = prog[a];
      end else begin
        progData = nop;
      end
    end
    @(negedge clk);
    progWe = 1'b0;
    repeat (2) @(negedge clk);
    rstN = 1'b1;

    waited = 0;
    while (expRd.size() != 0 && waited < drainLimit) begin
      @(posedge clk);
      waited++;
    end
    if (expRd.size() != 0) begin
      $display("timeout: %0d expected write-backs still missing after %0d cycles",
               expRd.size(), drainLimit);
      errors++;
    end

    // any write-back in this window is caught by the monitor
    repeat (idleCycles) @(posedge clk);
    check("writeCount", writesSeen, expWrites);

    $display("writes %0d of %0d, errors %0d", writesSeen, expWrites, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
hw/rvIsaPkg.sv
hw/pipePkg.sv
hw/instructionFetch.sv
hw/registerFile.sv
hw/decodeStage.sv
hw/forwardingUnit.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/cpu.sv
tb/cpuTb.sv

// ==== Makefile ====
SIM := obj_dir/VcpuTb

.PHONY: all run clean

all: run

$(SIM): build.f $(shell cat build.f)
	verilator --binary --timing -f build.f --top-module cpuTb -Mdir obj_dir -o VcpuTb

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "TB FAILED" sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
